// File: compile.f
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memwb_stage.sv
hdl/rv_core_top.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

// File: bench/rv_core_tb.sv
/*
  Directed testbench for the five-stage RV32I subset core.
  Each test loads a program with run low, predicts the retire
  list with an in-order instruction model, raises run and checks
  every retired register write in program order.
*/
module rv_core_tb;
  import rv_pkg::*;

  logic     clk;
  logic     rstn;
  logic     run;
  imem_wr_t prog;
  retire_t  retire;

  int          seed;
  int          mismatches;
  int          failures;
  logic [31:0] program_words [$];
  int          exp_rd [$];
  logic [31:0] exp_data [$];

  rv_core_top u_rv_core_top (
    .clk    (clk),
    .rstn   (rstn),
    .run    (run),
    .prog   (prog),
    .retire (retire)
  );

  bind rv_core_top rv_core_assertions u_rv_core_assertions (
    .clk            (clk),
    .rstn           (rstn),
    .stall          (stall),
    .redirect_valid (redirect.valid),
    .exmem_valid    (exmem.valid),
    .exmem_rd       (exmem.rd),
    .retire         (retire)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////
  function automatic logic [31:0] r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                         int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, logic [2:0] f3, int rd,
                                         logic [6:0] opc);
    logic [31:0] v;
    v = imm;
    return {v[11:0], 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
    logic [31:0] v;
    v = imm;
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], opc_store};
  endfunction

  // byte offset with bit 0 dropped
  function automatic logic [31:0] b_type(int imm, int rs2, int rs1, logic [2:0] f3);
    logic [31:0] v;
    v = imm;
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], opc_branch};
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    logic [31:0] v;
    v = imm;
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), opc_jal};
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // funct3 meaning per the ISA with sub only on funct7 bit 5
  function automatic logic [31:0] alu_result(logic [2:0] f3, logic sub, logic [31:0] a,
                                             logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'b000:  r = sub ? a - b : a + b;
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      3'b111:  r = a & b;
      default: r = 32'd0;
    endcase
    return r;
  endfunction

  // runs the program in order one instruction at a time
  task automatic compute_expected();
    logic [31:0] regs [32];
    logic [31:0] data_mem [int];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    int          pc;
    int          next_pc;
    int          steps;
    logic        writes;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    exp_rd.delete();
    exp_data.delete();
    pc    = 0;
    steps = 0;
    // ends when pc leaves the program
    while (pc >= 0 && pc / 4 < program_words.size() && steps < 1000) begin
      ins     = program_words[pc / 4];
      a       = regs[ins[19:15]];
      b       = regs[ins[24:20]];
      next_pc = pc + 4;
      writes  = 1'b1;
      res     = '0;
      case (ins[6:0])
        opc_op: begin
          res = alu_result(ins[14:12], ins[30], a, b);
        end
        opc_op_imm: begin
          res = alu_result(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
        end
        opc_load: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          res  = data_mem.exists(int'(addr[31:2])) ? data_mem[int'(addr[31:2])] : '0;
        end
        opc_store: begin
          addr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          writes = 1'b0;
          data_mem[int'(addr[31:2])] = b;
        end
        opc_branch: begin
          // funct3 bit 0 selects bne
          writes = 1'b0;
          if ((a == b) != ins[12]) begin
            next_pc = pc + int'({{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8],
                                 1'b0});
          end
        end
        opc_jal: begin
          res     = pc + 4;
          next_pc = pc + int'({{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21],
                               1'b0});
        end
        default: begin
          writes = 1'b0;
        end
      endcase
      if (writes && ins[11:7] != 5'd0) begin
        regs[ins[11:7]] = res;
        exp_rd.push_back(int'(ins[11:7]));
        exp_data.push_back(res);
      end
      pc = next_pc;
      steps++;
    end
  endtask

  //////////////////////////////////////////////////
  // drive and check helpers
  //////////////////////////////////////////////////
  task automatic apply_reset();
    @(negedge clk);
    rstn = 1'b0;
    run  = 1'b0;
    repeat (5) @(negedge clk);
    rstn = 1'b1;
  endtask

  // whole memory written and the addi x0 fill carries the word index
  task automatic load_program();
    for (int i = 0; i < imem_words; i++) begin
      @(negedge clk);
      prog.we    = 1'b1;
      prog.idx   = i[imem_addr_w-1:0];
      prog.instr = (i < program_words.size()) ? program_words[i]
                                              : i_type(i, 0, 3'b000, 0, opc_op_imm);
    end
    @(negedge clk);
    prog.we = 1'b0;
  endtask

  task automatic compare_retire(int idx);
    assert (retire.rd == 5'(exp_rd[idx])) else begin
      mismatches++;
      $display("mismatch at %0t: retire.rd expected %0d actual %0d",
               $time, exp_rd[idx], retire.rd);
    end
    assert (retire.data == exp_data[idx]) else begin
      mismatches++;
      $display("mismatch at %0t: retire.data expected %08h actual %08h",
               $time, exp_data[idx], retire.data);
    end
  endtask

  task automatic expect_no_retire(string name, int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      assert (!retire.valid) else begin
        failures++;
        $display("%s: unexpected retire of x%0d at %0t", name, retire.rd, $time);
      end
    end
  endtask

  // reset, load, predict, run, then watch a quiet window
  task automatic execute_program(string name);
    int seen;
    int cycles;
    apply_reset();
    load_program();
    compute_expected();
    @(negedge clk);
    run    = 1'b1;
    seen   = 0;
    cycles = 0;
    while (seen < exp_rd.size() && cycles < 1000) begin
      @(negedge clk);
      cycles++;
      if (retire.valid) begin
        compare_retire(seen);
        seen++;
      end
    end
    if (seen < exp_rd.size()) begin
      failures++;
      $display("%s: timed out after %0d of %0d register writes", name, seen,
               exp_rd.size());
    end
    expect_no_retire(name, 20);
    run = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  // program in place before the reset so a fetch that ignores run retires at once
  task automatic idle_while_run_low();
    program_words.delete();
    program_words.push_back(i_type(1, 0, 3'b000, 1, opc_op_imm));
    program_words.push_back(i_type(2, 0, 3'b000, 2, opc_op_imm));
    load_program();
    apply_reset();
    expect_no_retire("idle", 20);
  endtask

  // back-to-back dependences hit both forwarding sources
  task automatic alu_forwarding_chain();
    program_words.delete();
    program_words.push_back(i_type(5, 0, 3'b000, 1, opc_op_imm));
    program_words.push_back(i_type(7, 1, 3'b000, 2, opc_op_imm));
    program_words.push_back(r_type(7'h00, 2, 1, 3'b000, 3));
    program_words.push_back(r_type(7'h20, 1, 3, 3'b000, 4));
    program_words.push_back(r_type(7'h00, 3, 4, 3'b100, 5));
    program_words.push_back(r_type(7'h00, 2, 5, 3'b110, 6));
    program_words.push_back(r_type(7'h00, 3, 6, 3'b111, 7));
    program_words.push_back(r_type(7'h00, 4, 1, 3'b010, 8));
    program_words.push_back(i_type(-3, 4, 3'b010, 9, opc_op_imm));
    program_words.push_back(i_type(85, 9, 3'b100, 10, opc_op_imm));
    program_words.push_back(i_type(256, 10, 3'b110, 11, opc_op_imm));
    program_words.push_back(i_type(240, 11, 3'b111, 12, opc_op_imm));
    // negative x1 then signed compare against x0
    program_words.push_back(i_type(-20, 1, 3'b000, 1, opc_op_imm));
    program_words.push_back(r_type(7'h00, 0, 1, 3'b010, 13));
    execute_program("alu forwarding");
  endtask

  task automatic load_store_sequence();
    program_words.delete();
    program_words.push_back(i_type(64, 0, 3'b000, 1, opc_op_imm));
    program_words.push_back(i_type(123, 0, 3'b000, 2, opc_op_imm));
    program_words.push_back(s_type(0, 2, 1));
    program_words.push_back(i_type(0, 1, 3'b010, 3, opc_load));
    // load-use costs one bubble
    program_words.push_back(r_type(7'h00, 2, 3, 3'b000, 4));
    program_words.push_back(s_type(4, 4, 1));
    program_words.push_back(i_type(4, 1, 3'b010, 5, opc_load));
    program_words.push_back(i_type(1, 5, 3'b000, 6, opc_op_imm));
    // load data reaches the add through writeback
    program_words.push_back(i_type(0, 1, 3'b010, 7, opc_load));
    program_words.push_back(i_type(1, 0, 3'b000, 8, opc_op_imm));
    program_words.push_back(r_type(7'h00, 8, 7, 3'b000, 9));
    execute_program("load store");
  endtask

  task automatic branch_sequence();
    program_words.delete();
    program_words.push_back(i_type(3, 0, 3'b000, 1, opc_op_imm));
    program_words.push_back(i_type(3, 0, 3'b000, 2, opc_op_imm));
    // beq taken to 20 skips two
    program_words.push_back(b_type(12, 2, 1, 3'b000));
    program_words.push_back(i_type(1, 0, 3'b000, 3, opc_op_imm));
    program_words.push_back(i_type(2, 0, 3'b000, 4, opc_op_imm));
    // bne not taken
    program_words.push_back(b_type(12, 2, 1, 3'b001));
    program_words.push_back(i_type(5, 0, 3'b000, 5, opc_op_imm));
    program_words.push_back(i_type(1, 2, 3'b000, 2, opc_op_imm));
    // bne taken to 44
    program_words.push_back(b_type(12, 2, 1, 3'b001));
    program_words.push_back(i_type(6, 0, 3'b000, 6, opc_op_imm));
    program_words.push_back(i_type(7, 0, 3'b000, 7, opc_op_imm));
    // beq not taken
    program_words.push_back(b_type(8, 2, 1, 3'b000));
    program_words.push_back(i_type(8, 0, 3'b000, 8, opc_op_imm));
    // countdown loop with a backward bne
    program_words.push_back(i_type(3, 0, 3'b000, 10, opc_op_imm));
    program_words.push_back(i_type(-1, 10, 3'b000, 10, opc_op_imm));
    program_words.push_back(b_type(-4, 0, 10, 3'b001));
    program_words.push_back(i_type(11, 0, 3'b000, 11, opc_op_imm));
    execute_program("branches");
  endtask

  task automatic jal_sequence();
    program_words.delete();
    program_words.push_back(i_type(1, 0, 3'b000, 1, opc_op_imm));
    // jal x5 to 16 with link 8
    program_words.push_back(j_type(12, 5));
    program_words.push_back(i_type(2, 0, 3'b000, 2, opc_op_imm));
    program_words.push_back(i_type(3, 0, 3'b000, 3, opc_op_imm));
    program_words.push_back(i_type(0, 5, 3'b000, 4, opc_op_imm));
    // jal x0 writes nothing
    program_words.push_back(j_type(8, 0));
    program_words.push_back(i_type(6, 0, 3'b000, 6, opc_op_imm));
    program_words.push_back(i_type(1, 4, 3'b000, 7, opc_op_imm));
    execute_program("jal");
  endtask

  // small register window keeps dependences dense
  function automatic logic [31:0] random_alu_instr();
    int          pick;
    int          rd;
    int          rs1;
    int          rs2;
    int          imm;
    logic [31:0] w;
    pick = $unsigned($random(seed)) % 11;
    rd   = $unsigned($random(seed)) % 8;
    rs1  = $unsigned($random(seed)) % 8;
    rs2  = $unsigned($random(seed)) % 8;
    imm  = $random(seed) % 2048;
    case (pick)
      0:       w = r_type(7'h00, rs2, rs1, 3'b000, rd);
      1:       w = r_type(7'h20, rs2, rs1, 3'b000, rd);
      2:       w = r_type(7'h00, rs2, rs1, 3'b111, rd);
      3:       w = r_type(7'h00, rs2, rs1, 3'b110, rd);
      4:       w = r_type(7'h00, rs2, rs1, 3'b100, rd);
      5:       w = r_type(7'h00, rs2, rs1, 3'b010, rd);
      6:       w = i_type(imm, rs1, 3'b000, rd, opc_op_imm);
      7:       w = i_type(imm, rs1, 3'b111, rd, opc_op_imm);
      8:       w = i_type(imm, rs1, 3'b110, rd, opc_op_imm);
      9:       w = i_type(imm, rs1, 3'b100, rd, opc_op_imm);
      default: w = i_type(imm, rs1, 3'b010, rd, opc_op_imm);
    endcase
    return w;
  endfunction

  task automatic random_alu_programs();
    for (int n = 0; n < 3; n++) begin
      program_words.delete();
      for (int k = 0; k < 40; k++) begin
        program_words.push_back(random_alu_instr());
      end
      execute_program("random");
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    seed       = 17;
    mismatches = 0;
    failures   = 0;
    rstn       = 1'b0;
    run        = 1'b0;
    prog       = '0;
    idle_while_run_low();
    alu_forwarding_chain();
    load_store_sequence();
    branch_sequence();
    jal_sequence();
    random_alu_programs();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: bench/rv_core_assertions.sv
/*
  Concurrent checks on the core top level, attached by bind from
  the testbench. Watches the retire port against the EX/MEM
  payload, and the stall and redirect levels in the cycle that
  follows a reset edge.
*/
module rv_core_assertions (
  input logic             clk,
  input logic             rstn,
  input logic             stall,
  input logic             redirect_valid,
  input logic             exmem_valid,
  input rv_pkg::reg_idx_t exmem_rd,
  input rv_pkg::retire_t  retire
);

  // an x0 write leaving ex/mem stays silent on the retire port
  retire_not_x0: assert property (@(posedge clk) disable iff (!rstn)
    (exmem_valid && exmem_rd == '0) |=> !retire.valid)
    else $error("retire reported a write to x0");

  // pipeline is empty right after a reset edge
  quiet_after_reset: assert property (@(posedge clk)
    !rstn |=> (!stall && !redirect_valid))
    else $error("stall or redirect active in the cycle after reset");

  retire_valid_known: assert property (@(posedge clk) disable iff (!rstn)
    !$isunknown(retire.valid))
    else $error("retire valid is unknown after reset");

endmodule

// File: hdl/rv_core_top.sv
/*
  Top level of the five-stage RV32I subset core. Chains fetch,
  decode, execute and memory/writeback. Load code through prog
  with run low, then raise run. An instruction fetched at edge n
  retires at edge n+4, one cycle later per load-use stall.
*/
module rv_core_top (
  input  logic             clk,
  input  logic             rstn,
  input  logic             run,
  input  rv_pkg::imem_wr_t prog,
  output rv_pkg::retire_t  retire
);
  import rv_pkg::*;

  //////////////////////////////////////////////////
  // stage links
  //////////////////////////////////////////////////
  ifid_t     ifid;
  idex_t     idex;
  exmem_t    exmem;
  memwb_t    memwb;
  redirect_t redirect;
  // load-use hold from decode to fetch
  logic      stall;

  fetch_stage u_fetch_stage (
    .clk      (clk),
    .rstn     (rstn),
    .run      (run),
    .prog     (prog),
    .stall    (stall),
    .redirect (redirect),
    .ifid     (ifid)
  );

  // memwb doubles as the register file write port
  decode_stage u_decode_stage (
    .clk      (clk),
    .rstn     (rstn),
    .ifid     (ifid),
    .redirect (redirect),
    .wb       (memwb),
    .stall    (stall),
    .idex     (idex)
  );

  // ex/mem output looped back as the memory-stage source
  execute_stage u_execute_stage (
    .clk      (clk),
    .rstn     (rstn),
    .idex     (idex),
    .mem_fwd  (exmem),
    .wb_fwd   (memwb),
    .redirect (redirect),
    .exmem    (exmem)
  );

  memwb_stage u_memwb_stage (
    .clk    (clk),
    .rstn   (rstn),
    .exmem  (exmem),
    .memwb  (memwb),
    .retire (retire)
  );

endmodule

// File: hdl/memwb_stage.sv
/*
  Memory and writeback stage. Holds the word data memory, indexed
  by the word address in the EX/MEM result. Stores write on the
  edge, loads read asynchronously. Registers the MEM/WB payload
  that feeds the register file and forwarding, and reports each
  nonzero register write on the retire port.
*/
module memwb_stage (
  input  logic            clk,
  input  logic            rstn,
  input  rv_pkg::exmem_t  exmem,
  output rv_pkg::memwb_t  memwb,
  output rv_pkg::retire_t retire
);
  import rv_pkg::*;

  logic [$clog2(dmem_words)-1:0] dmem_idx;
  word_t                         load_data;
  memwb_t                        memwb_d;
  word_t                         dmem [dmem_words];

  //////////////////////////////////////////////////
  // data memory
  //////////////////////////////////////////////////
  // word access only, low two address bits dropped
  assign dmem_idx = exmem.result[$clog2(dmem_words)+1:2];

  always_ff @(posedge clk) begin
    if (exmem.valid && exmem.is_store) begin
      dmem[dmem_idx] <= exmem.store_data;
    end
  end

  assign load_data = dmem[dmem_idx];

  //////////////////////////////////////////////////
  // mem/wb register
  //////////////////////////////////////////////////
  always_comb begin
    memwb_d.valid     = exmem.valid;
    memwb_d.rd        = exmem.rd;
    memwb_d.data      = exmem.is_load ? load_data : exmem.result;
    memwb_d.reg_write = exmem.reg_write;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      memwb.valid <= 1'b0;
    end else begin
      memwb <= memwb_d;
    end
  end

  // retire report, in program order
  // x0 writes and non-writing instructions stay silent
  always_comb begin
    retire.valid = memwb.valid && memwb.reg_write && (memwb.rd != '0);
    retire.rd    = memwb.rd;
    retire.data  = memwb.data;
  end

endmodule

// File: hdl/execute_stage.sv
/*
  Execute stage. Picks forwarded operands from the memory and
  writeback stages, runs the ALU and resolves BEQ, BNE and JAL.
  A taken branch or any JAL raises redirect for one cycle.
  Registers the EX/MEM payload, with pc+4 as the JAL result.
*/
module execute_stage (
  input  logic              clk,
  input  logic              rstn,
  input  rv_pkg::idex_t     idex,
  input  rv_pkg::exmem_t    mem_fwd,
  input  rv_pkg::memwb_t    wb_fwd,
  output rv_pkg::redirect_t redirect,
  output rv_pkg::exmem_t    exmem
);
  import rv_pkg::*;

  word_t  op_a;
  word_t  rs2_fwd;
  word_t  op_b;
  word_t  alu_res;
  logic   eq;
  logic   taken;
  exmem_t exmem_d;

  //////////////////////////////////////////////////
  // forwarding
  //////////////////////////////////////////////////
  // memory stage first, loads excluded since stall covers them
  function automatic word_t fwd_sel(reg_idx_t idx, word_t reg_val);
    word_t val;
    if (mem_fwd.valid && mem_fwd.reg_write && !mem_fwd.is_load &&
        mem_fwd.rd != '0 && mem_fwd.rd == idx) begin
      val = mem_fwd.result;
    end else if (wb_fwd.valid && wb_fwd.reg_write &&
                 wb_fwd.rd != '0 && wb_fwd.rd == idx) begin
      val = wb_fwd.data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  always_comb begin
    op_a    = fwd_sel(idex.rs1, idex.rs1_val);
    rs2_fwd = fwd_sel(idex.rs2, idex.rs2_val);
    // store data keeps rs2, immediate only goes to the alu
    op_b    = idex.use_imm ? idex.imm : rs2_fwd;
  end

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////
  always_comb begin
    case (idex.alu_op)
      alu_sub: alu_res = op_a - op_b;
      alu_and: alu_res = op_a & op_b;
      alu_or:  alu_res = op_a | op_b;
      alu_xor: alu_res = op_a ^ op_b;
      alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_res = op_a + op_b;
    endcase
  end

  // branch compare on forwarded registers
  assign eq    = (op_a == rs2_fwd);
  assign taken = idex.is_branch && (eq != idex.is_branch_ne);

  // one-cycle pulse, target is pc plus immediate for both kinds
  always_comb begin
    redirect.valid  = idex.valid && (taken || idex.is_jal);
    redirect.target = idex.pc + idex.imm;
  end

  //////////////////////////////////////////////////
  // ex/mem register
  //////////////////////////////////////////////////
  always_comb begin
    exmem_d.valid      = idex.valid;
    exmem_d.result     = idex.is_jal ? idex.pc + xlen'(4) : alu_res;
    exmem_d.store_data = rs2_fwd;
    exmem_d.rd         = idex.rd;
    exmem_d.is_load    = idex.is_load;
    exmem_d.is_store   = idex.is_store;
    exmem_d.reg_write  = idex.reg_write;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      exmem.valid <= 1'b0;
    end else begin
      exmem <= exmem_d;
    end
  end

endmodule

// File: hdl/decode_stage.sv
/*
  Decode stage. Splits the instruction, maps it to the control
  flags and ALU function, builds the immediate and reads the
  register file, whose write port is fed from writeback. Raises
  stall for a load-use hazard and registers the ID/EX payload,
  turning it into a bubble on stall or redirect.
*/
module decode_stage (
  input  logic              clk,
  input  logic              rstn,
  input  rv_pkg::ifid_t     ifid,
  input  rv_pkg::redirect_t redirect,
  input  rv_pkg::memwb_t    wb,
  output logic              stall,
  output rv_pkg::idex_t     idex
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  alu_op_e    alu_sel;
  word_t      rs1_val;
  word_t      rs2_val;
  idex_t      idex_d;
  word_t      regs [2**reg_addr_w];

  //////////////////////////////////////////////////
  // fields and immediates
  //////////////////////////////////////////////////
  assign opcode   = opcode_e'(ifid.instr[6:0]);
  assign funct3   = ifid.instr[14:12];
  assign funct7_5 = ifid.instr[30];
  assign rd       = ifid.instr[11:7];
  assign rs1      = ifid.instr[19:15];
  assign rs2      = ifid.instr[24:20];

  assign imm_i = {{20{ifid.instr[31]}}, ifid.instr[31:20]};
  assign imm_s = {{20{ifid.instr[31]}}, ifid.instr[31:25], ifid.instr[11:7]};
  assign imm_b = {{19{ifid.instr[31]}}, ifid.instr[31], ifid.instr[7],
                  ifid.instr[30:25], ifid.instr[11:8], 1'b0};
  assign imm_j = {{11{ifid.instr[31]}}, ifid.instr[31], ifid.instr[19:12],
                  ifid.instr[20], ifid.instr[30:21], 1'b0};

  // funct3 shared by op and op-imm
  always_comb begin
    case (funct3)
      3'b000:  alu_sel = (opcode == opc_op && funct7_5) ? alu_sub : alu_add;
      3'b010:  alu_sel = alu_slt;
      3'b100:  alu_sel = alu_xor;
      3'b110:  alu_sel = alu_or;
      3'b111:  alu_sel = alu_and;
      default: alu_sel = alu_add;
    endcase
  end

  //////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////
  // x0 never written
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // same-cycle write bypassed into the read
  function automatic word_t rf_read(reg_idx_t idx);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wb.valid && wb.reg_write && wb.rd == idx) begin
      val = wb.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    rs1_val = rf_read(rs1);
    rs2_val = rf_read(rs2);
  end

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  always_comb begin
    idex_d         = '0;
    // instruction behind a redirect is dropped here
    idex_d.valid   = ifid.valid && !redirect.valid;
    idex_d.pc      = ifid.pc;
    idex_d.rs1_val = rs1_val;
    idex_d.rs2_val = rs2_val;
    idex_d.rs1     = rs1;
    idex_d.rs2     = rs2;
    idex_d.rd      = rd;
    idex_d.alu_op  = alu_add;
    case (opcode)
      opc_op: begin
        idex_d.alu_op    = alu_sel;
        idex_d.reg_write = 1'b1;
      end
      opc_op_imm: begin
        idex_d.alu_op    = alu_sel;
        idex_d.imm       = imm_i;
        idex_d.use_imm   = 1'b1;
        idex_d.reg_write = 1'b1;
      end
      opc_load: begin
        idex_d.imm       = imm_i;
        idex_d.use_imm   = 1'b1;
        idex_d.is_load   = 1'b1;
        idex_d.reg_write = 1'b1;
      end
      opc_store: begin
        idex_d.imm      = imm_s;
        idex_d.use_imm  = 1'b1;
        idex_d.is_store = 1'b1;
      end
      opc_branch: begin
        // beq 000, bne 001
        idex_d.imm          = imm_b;
        idex_d.is_branch    = 1'b1;
        idex_d.is_branch_ne = funct3[0];
      end
      opc_jal: begin
        idex_d.imm       = imm_j;
        idex_d.is_jal    = 1'b1;
        idex_d.reg_write = 1'b1;
      end
      default: begin
        // unknown opcode moves on with no effect
        idex_d.reg_write = 1'b0;
      end
    endcase
  end

  // load in id/ex feeding this instruction
  assign stall = ifid.valid && idex.valid && idex.is_load && (idex.rd != '0) &&
                 ((idex.rd == rs1) || (idex.rd == rs2));

  // id/ex register, bubble while stalled
  always_ff @(posedge clk) begin
    if (!rstn) begin
      idex.valid <= 1'b0;
    end else if (stall) begin
      idex.valid <= 1'b0;
    end else begin
      idex <= idex_d;
    end
  end

endmodule

// File: hdl/fetch_stage.sv
/*
  Fetch stage. Owns the program counter, the instruction memory
  and the IF/ID register. The memory is filled through the load
  port while run is low. With run high the PC steps by 4, holds
  on a load-use stall, or jumps to the execute redirect target.
*/
module fetch_stage (
  input  logic              clk,
  input  logic              rstn,
  input  logic              run,
  input  rv_pkg::imem_wr_t  prog,
  input  logic              stall,
  input  rv_pkg::redirect_t redirect,
  output rv_pkg::ifid_t     ifid
);
  import rv_pkg::*;

  word_t pc;
  word_t instr;
  word_t imem [imem_words];

  //////////////////////////////////////////////////
  // instruction memory
  //////////////////////////////////////////////////
  // one word per cycle from the load port
  always_ff @(posedge clk) begin
    if (prog.we) begin
      imem[prog.idx] <= prog.instr;
    end
  end

  // async read at the pc word index
  assign instr = imem[pc[imem_addr_w+1:2]];

  //////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////
  // redirect wins over stall
  always_ff @(posedge clk) begin
    if (!rstn || !run) begin
      pc <= '0;
    end else if (redirect.valid) begin
      pc <= redirect.target;
    end else if (!stall) begin
      pc <= pc + xlen'(4);
    end
  end

  // if/id register
  // wrong-path word dropped on redirect, bubbles while idle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ifid.valid <= 1'b0;
    end else if (redirect.valid || !run) begin
      ifid.valid <= 1'b0;
    end else if (!stall) begin
      ifid.valid <= 1'b1;
      ifid.pc    <= pc;
      ifid.instr <= instr;
    end
  end

endmodule

// File: hdl/rv_pkg.sv
/*
  Shared definitions for the five-stage RV32I subset core.
  Holds the widths, memory depths, opcode and ALU encodings,
  and the packed payload structs that travel between stages.
  Compile it first. Each stage imports it inside its body.
*/
package rv_pkg;

  //////////////////////////////////////////////////
  // widths and depths
  //////////////////////////////////////////////////
  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int imem_words  = 256;
  localparam int dmem_words  = 256;
  localparam int imem_addr_w = 8;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////
  // major opcodes kept by the decoder
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  // alu functions, sub only from r-type
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  //////////////////////////////////////////////////
  // stage payloads
  //////////////////////////////////////////////////
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } ifid_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_e  alu_op;
    // control flags
    logic     use_imm;
    logic     is_load;
    logic     is_store;
    logic     is_branch_ne;
    logic     is_branch;
    logic     is_jal;
    logic     reg_write;
  } idex_t;

  // result is pc+4 for jal
  typedef struct packed {
    logic     valid;
    word_t    result;
    word_t    store_data;
    reg_idx_t rd;
    logic     is_load;
    logic     is_store;
    logic     reg_write;
  } exmem_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
    logic     reg_write;
  } memwb_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

  typedef struct packed {
    logic                   we;
    logic [imem_addr_w-1:0] idx;
    word_t                  instr;
  } imem_wr_t;

endpackage
